//--- tb.f
+incdir+rtl
rtl/la_pkg.sv
rtl/la_trigger_match.sv
rtl/la_sample_ram.sv
rtl/la_capture_ctrl.sv
rtl/la_readout.sv
rtl/logic_analyzer_top.sv
dv/tb_logic_analyzer.sv

//--- Bender.yml
package:
  name: logic_analyzer

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/la_pkg.sv
      - rtl/la_trigger_match.sv
      - rtl/la_sample_ram.sv
      - rtl/la_capture_ctrl.sv
      - rtl/la_readout.sv
      - rtl/logic_analyzer_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - dv/tb_logic_analyzer.sv

//--- dv/tb_logic_analyzer.sv
`timescale 1ns/100ps
`include "la_defs.svh"

module tb_logic_analyzer;

  localparam int NUM_TESTS       = 9;
  localparam int CYCLES_PER_TEST = 500;
  localparam int CLK_PERIOD      = 20;
  localparam int MAX_WRITES      = 512;

  logic            i_cap_clk;
  logic            rst;
  la_pkg::sample_t i_cap_data;
  logic            i_ext_trig;
  la_pkg::sample_t i_trig_value;
  la_pkg::sample_t i_trig_mask;
  la_pkg::sample_t i_trig_edge;
  la_pkg::sample_t i_trig_both;
  logic [31:0]     i_pre_count;
  logic [31:0]     i_repeat_count;
  logic            i_force;
  logic            i_enable;
  logic            i_read_start;
  logic            i_credit_ret;
  logic            o_rd_valid;
  la_pkg::sample_t o_rd_data;
  logic            o_read_done;
  logic            o_finished;
  la_pkg::ptr_t    o_capture_start;

  // One entry per test
  string t_name [NUM_TESTS] = '{"level_p0", "pre_history", "rising_edge", "falling_edge",
                                "both_edges", "repeat_count", "ext_trig", "force_idle",
                                "random_credits"};
  logic [31:0] t_value [NUM_TESTS] = '{32'h5, 32'h9, 32'h28, 32'h0, 32'h0, 32'h3,
                                       32'hffff_ffff, 32'hffff_ffff, 32'h7};
  logic [31:0] t_mask  [NUM_TESTS] = '{32'hf, 32'hf, 32'h28, 32'h4, 32'h10, 32'h7,
                                       32'hffff_ffff, 32'hffff_ffff, 32'hf};
  logic [31:0] t_edge  [NUM_TESTS] = '{32'h0, 32'h0, 32'h8, 32'h4, 32'h10, 32'h0,
                                       32'h0, 32'h0, 32'h0};
  logic [31:0] t_both  [NUM_TESTS] = '{32'h0, 32'h0, 32'h0, 32'h0, 32'h10, 32'h0,
                                       32'h0, 32'h0, 32'h0};
  int t_pre      [NUM_TESTS] = '{0, 10, 4, 0, 2, 5, 8, 0, 20};
  int t_rep      [NUM_TESTS] = '{0, 0, 0, 0, 0, 2, 0, 0, 1};
  int t_inj_kind [NUM_TESTS] = '{0, 0, 0, 0, 0, 0, 1, 2, 0};   // 1 external, 2 force
  int t_inj_cyc  [NUM_TESTS] = '{-1, -1, -1, -1, -1, -1, 20, 0, -1};
  int t_cred_dly [NUM_TESTS] = '{1, 9, 0, 7, 2, 3, 1, 4, -1};  // -1 is random

  int              errors;
  int              seed;
  int              cyc;
  int              cur;
  la_pkg::sample_t prev_sample;
  la_pkg::sample_t data_q [$];
  la_pkg::sample_t prev_q [$];
  bit              ext_q [$];
  bit              force_q [$];
  int              due_q [$];

  initial i_cap_clk = 1'b0;
  always #(CLK_PERIOD / 2) i_cap_clk = ~i_cap_clk;

  logic_analyzer_top uut (
    .i_cap_clk       (i_cap_clk),
    .rst             (rst),
    .i_cap_data      (i_cap_data),
    .i_ext_trig      (i_ext_trig),
    .i_trig_value    (i_trig_value),
    .i_trig_mask     (i_trig_mask),
    .i_trig_edge     (i_trig_edge),
    .i_trig_both     (i_trig_both),
    .i_pre_count     (i_pre_count),
    .i_repeat_count  (i_repeat_count),
    .i_force         (i_force),
    .i_enable        (i_enable),
    .i_read_start    (i_read_start),
    .i_credit_ret    (i_credit_ret),
    .o_rd_valid      (o_rd_valid),
    .o_rd_data       (o_rd_data),
    .o_read_done     (o_read_done),
    .o_finished      (o_finished),
    .o_capture_start (o_capture_start)
  );

  task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("** Error %s: %s expected %h, actual %h", t_name[cur], what, exp, act);
    end
  endtask

  // Probe bus counts up once per cycle
  task automatic next_cycle();
    @(posedge i_cap_clk);
    #2;
    cyc++;
    prev_sample = i_cap_data;
    i_cap_data  = i_cap_data + 1;
  endtask

  function automatic bit rule_match(input la_pkg::sample_t d, input la_pkg::sample_t p,
                                    input int row);
    bit ok;
    ok = 1'b1;
    for (int i = 0; i < `LA_SAMPLE_W; i++) begin
      if (t_mask[row][i]) begin
        if (!t_edge[row][i]) begin
          ok &= (d[i] == t_value[row][i]);
        end else if (t_both[row][i]) begin
          ok &= (d[i] != p[i]);
        end else if (t_value[row][i]) begin
          ok &= (d[i] && !p[i]);      // Rising
        end else begin
          ok &= (!d[i] && p[i]);      // Falling
        end
      end
    end
    return ok;
  endfunction

  // Index of the trigger sample among the written samples or -1 if none
  function automatic int find_trigger(input int row);
    int events;
    events = 0;
    for (int k = 0; k < data_q.size(); k++) begin
      if (force_q[k]) begin
        return k;
      end
      if (k >= t_pre[row] && (ext_q[k] || rule_match(data_q[k], prev_q[k], row))) begin
        if (events == t_rep[row]) begin
          return k;
        end
        events++;
      end
    end
    return -1;
  endfunction

  task automatic run_test(input int row);
    int          trig_k;
    int          first_k;
    int          n_valid;
    int          n_done;
    int          n_ret;
    int          dly;
    logic [31:0] rnd;
    bit          done;

    cur = row;
    data_q.delete();
    prev_q.delete();
    ext_q.delete();
    force_q.delete();
    due_q.delete();
    i_trig_value   = t_value[row];
    i_trig_mask    = t_mask[row];
    i_trig_edge    = t_edge[row];
    i_trig_both    = t_both[row];
    i_pre_count    = t_pre[row];
    i_repeat_count = t_rep[row];
    next_cycle();

    // Capture and record every written sample
    i_enable = 1'b1;
    done = 1'b0;
    while (!done) begin
      i_ext_trig = (t_inj_kind[row] == 1) && (data_q.size() == t_inj_cyc[row]);
      i_force    = (t_inj_kind[row] == 2) && (data_q.size() == t_inj_cyc[row]);
      data_q.push_back(i_cap_data);
      prev_q.push_back(prev_sample);
      ext_q.push_back(i_ext_trig);
      force_q.push_back(i_force);
      next_cycle();
      done = o_finished || (data_q.size() >= MAX_WRITES);
    end
    i_ext_trig = 1'b0;
    i_force    = 1'b0;

    trig_k = find_trigger(row);
    if (!o_finished || trig_k < 0) begin
      errors++;
      $display("%s: capture did not finish on a predicted trigger", t_name[row]);
      i_enable = 1'b0;
      next_cycle();
      return;
    end
    first_k = trig_k - t_pre[row];
    check("write count", trig_k + `LA_DEPTH - t_pre[row], data_q.size());
    check("capture start", first_k % `LA_DEPTH, o_capture_start);

    i_read_start = 1'b1;
    next_cycle();
    i_read_start = 1'b0;
    n_valid = 0;
    n_done  = 0;
    n_ret   = 0;
    while (n_done == 0 || due_q.size() != 0) begin
      if (due_q.size() != 0 && due_q[0] <= cyc) begin
        void'(due_q.pop_front());
        i_credit_ret = 1'b1;
        n_ret++;
      end else begin
        i_credit_ret = 1'b0;
      end
      next_cycle();
      if (o_rd_valid) begin
        if (n_valid < `LA_DEPTH) begin
          check($sformatf("sample %0d", n_valid), data_q[first_k + n_valid], o_rd_data);
        end else begin
          errors++;
          $display("%s: readout sent more than %0d samples", t_name[row], `LA_DEPTH);
        end
        n_valid++;
        if (t_cred_dly[row] < 0) begin
          rnd = $random(seed);
          dly = int'(rnd[2:0]) + 1;
        end else begin
          dly = t_cred_dly[row];
        end
        due_q.push_back(cyc + dly);
      end
      if (o_read_done) begin
        n_done++;
        check("valids before read_done", `LA_DEPTH, n_valid);
      end
      if (n_valid - n_ret > `LA_CREDITS) begin
        errors++;
        $display("%s: %0d samples outstanding with only %0d credits", t_name[row],
                 n_valid - n_ret, `LA_CREDITS);
      end
    end
    i_credit_ret = 1'b0;
    check("valid count", `LA_DEPTH, n_valid);
    check("read_done pulses", 1, n_done);

    i_enable = 1'b0;
    next_cycle();
    next_cycle();
    check("finished after disable", 0, o_finished);
    check("valid after readout", 0, o_rd_valid);
    check("read_done after readout", 0, o_read_done);
  endtask

  initial begin
    errors         = 0;
    seed           = 32'h5d99;
    cyc            = 0;
    cur            = 0;
    prev_sample    = '0;
    rst            = 1'b1;
    i_cap_data     = '0;
    i_ext_trig     = 1'b0;
    i_trig_value   = '0;
    i_trig_mask    = '0;
    i_trig_edge    = '0;
    i_trig_both    = '0;
    i_pre_count    = '0;
    i_repeat_count = '0;
    i_force        = 1'b0;
    i_enable       = 1'b0;
    i_read_start   = 1'b0;
    i_credit_ret   = 1'b0;
    repeat (2) @(posedge i_cap_clk);
    #2;
    rst = 1'b0;
    repeat (3) next_cycle();

    for (int row = 0; row < NUM_TESTS; row++) begin
      run_test(row);
    end

    $display("Ran %0d tests, %0d errors", NUM_TESTS, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    la_pkg::cap_state_e st;
    #(CLK_PERIOD * CYCLES_PER_TEST * NUM_TESTS);
    st = uut.u_ctrl.state;
    $display("Timeout: the run did not complete in %0d cycles, stuck in test %s (FSM %s)",
             CYCLES_PER_TEST * NUM_TESTS, t_name[cur], st.name());
    $display("Ran %0d tests, %0d errors", cur, errors);
    $display("Test failures found");
    $finish;
  end

endmodule

//--- rtl/logic_analyzer_top.sv
`timescale 1ns/100ps
`include "la_defs.svh"

module logic_analyzer_top (
  input  logic            i_cap_clk,
  input  logic            rst,
  input  la_pkg::sample_t i_cap_data,
  input  logic            i_ext_trig,
  input  la_pkg::sample_t i_trig_value,
  input  la_pkg::sample_t i_trig_mask,
  input  la_pkg::sample_t i_trig_edge,
  input  la_pkg::sample_t i_trig_both,
  input  logic [31:0]     i_pre_count,
  input  logic [31:0]     i_repeat_count,
  input  logic            i_force,
  input  logic            i_enable,
  input  logic            i_read_start,
  input  logic            i_credit_ret,
  output logic            o_rd_valid,
  output la_pkg::sample_t o_rd_data,
  output logic            o_read_done,
  output logic            o_finished,
  output la_pkg::ptr_t    o_capture_start
);

  logic            match;
  logic            wr_en;
  la_pkg::ptr_t    wr_addr;
  la_pkg::sample_t wr_data;
  la_pkg::ptr_t    rd_addr;
  la_pkg::sample_t ram_data;

  la_trigger_match u_trig (
    .i_cap_clk    (i_cap_clk),
    .rst          (rst),
    .i_cap_data   (i_cap_data),
    .i_trig_value (i_trig_value),
    .i_trig_mask  (i_trig_mask),
    .i_trig_edge  (i_trig_edge),
    .i_trig_both  (i_trig_both),
    .o_match      (match)
  );

  la_capture_ctrl u_ctrl (
    .i_cap_clk       (i_cap_clk),
    .rst             (rst),
    .i_cap_data      (i_cap_data),
    .i_match         (match),
    .i_ext_trig      (i_ext_trig),
    .i_force         (i_force),
    .i_enable        (i_enable),
    .i_pre_count     (i_pre_count),
    .i_repeat_count  (i_repeat_count),
    .o_wr_en         (wr_en),
    .o_wr_addr       (wr_addr),
    .o_wr_data       (wr_data),
    .o_finished      (o_finished),
    .o_capture_start (o_capture_start)
  );

  la_sample_ram u_ram (
    .i_cap_clk (i_cap_clk),
    .i_wr_en   (wr_en),
    .i_wr_addr (wr_addr),
    .i_wr_data (wr_data),
    .i_rd_addr (rd_addr),
    .o_rd_data (ram_data)
  );

  la_readout u_rdout (
    .i_cap_clk       (i_cap_clk),
    .rst             (rst),
    .i_finished      (o_finished),
    .i_capture_start (o_capture_start),
    .i_read_start    (i_read_start),
    .i_credit_ret    (i_credit_ret),
    .i_ram_data      (ram_data),
    .o_rd_addr       (rd_addr),
    .o_rd_valid      (o_rd_valid),
    .o_rd_data       (o_rd_data),
    .o_read_done     (o_read_done)
  );

endmodule

//--- rtl/la_readout.sv
`timescale 1ns/100ps
`include "la_defs.svh"

module la_readout (
  input  logic            i_cap_clk,
  input  logic            rst,
  input  logic            i_finished,
  input  la_pkg::ptr_t    i_capture_start,
  input  logic            i_read_start,
  input  logic            i_credit_ret,
  input  la_pkg::sample_t i_ram_data,
  output la_pkg::ptr_t    o_rd_addr,
  output logic            o_rd_valid,
  output la_pkg::sample_t o_rd_data,
  output logic            o_read_done
);

  localparam int CRED_W = $clog2(`LA_CREDITS + 1);
  localparam int CNT_W  = `LA_DEPTH_LOG2 + 1;

  logic [CRED_W-1:0] credits;
  logic [CNT_W-1:0]  remaining;
  la_pkg::ptr_t      rd_ptr;
  logic              busy;
  logic              issue;
  logic              last_valid;

  // Never issue without a credit
  assign issue = busy & (remaining != '0) & (credits != '0);

  // Valid of the final issue arrives after remaining has hit zero
  assign last_valid = busy & o_rd_valid & (remaining == '0);

  assign o_rd_addr = rd_ptr;
  assign o_rd_data = i_ram_data;

  always_ff @(posedge i_cap_clk) begin
    if (rst) begin
      credits <= CRED_W'(`LA_CREDITS);
    end else begin
      // Issue and return in one cycle cancel out
      credits <= credits + CRED_W'(i_credit_ret) - CRED_W'(issue);
    end
  end

  always_ff @(posedge i_cap_clk) begin
    if (rst) begin
      busy      <= 1'b0;
      rd_ptr    <= '0;
      remaining <= '0;
    end else if (!busy && i_finished && i_read_start) begin
      busy      <= 1'b1;
      rd_ptr    <= i_capture_start;
      remaining <= CNT_W'(`LA_DEPTH);
    end else if (issue) begin
      rd_ptr    <= rd_ptr + 1'b1;     // Wraps around the ring
      remaining <= remaining - 1'b1;
    end else if (last_valid) begin
      busy <= 1'b0;
    end
  end

  // Match the memory's read latency
  always_ff @(posedge i_cap_clk) begin
    if (rst) begin
      o_rd_valid  <= 1'b0;
      o_read_done <= 1'b0;
    end else begin
      o_rd_valid  <= issue;
      o_read_done <= last_valid;
    end
  end

endmodule

//--- rtl/la_capture_ctrl.sv
`timescale 1ns/100ps
`include "la_defs.svh"

module la_capture_ctrl (
  input  logic            i_cap_clk,
  input  logic            rst,
  input  la_pkg::sample_t i_cap_data,
  input  logic            i_match,
  input  logic            i_ext_trig,
  input  logic            i_force,
  input  logic            i_enable,
  input  logic [31:0]     i_pre_count,
  input  logic [31:0]     i_repeat_count,
  output logic            o_wr_en,
  output la_pkg::ptr_t    o_wr_addr,
  output la_pkg::sample_t o_wr_data,
  output logic            o_finished,
  output la_pkg::ptr_t    o_capture_start
);

  localparam int HIST_W = `LA_DEPTH_LOG2 + 1;
  localparam logic [HIST_W-1:0] HIST_MAX = HIST_W'(`LA_DEPTH);

  la_pkg::cap_state_e state;
  la_pkg::ptr_t       wr_ptr;
  la_pkg::ptr_t       trig_addr;
  la_pkg::ptr_t       pre_ptr;
  la_pkg::ptr_t       post_ptr;
  la_pkg::ptr_t       end_ptr;
  logic [HIST_W-1:0]  hist_cnt;
  logic [31:0]        rep_cnt;
  logic               armed;
  logic               count_evt;
  logic               fire;
  logic               at_end;

  // P is below LA_DEPTH, so the low bits carry all of it
  assign pre_ptr  = i_pre_count[`LA_DEPTH_LOG2-1:0];
  assign post_ptr = la_pkg::ptr_t'(`LA_DEPTH - 1) - pre_ptr;
  assign end_ptr  = trig_addr + post_ptr;

  // Enough history written before this cycle
  assign armed = {{(32 - HIST_W){1'b0}}, hist_cnt} >= i_pre_count;

  assign count_evt = armed & (i_match | i_ext_trig);

  // Force skips both the history wait and the repeat count
  assign fire = i_force | (count_evt & (rep_cnt == i_repeat_count));

  assign at_end = (state == la_pkg::CAPTURE) & (wr_ptr == end_ptr);

  // Every enabled cycle writes until the window is complete
  assign o_wr_en   = i_enable & (state != la_pkg::FINISHED);
  assign o_wr_addr = wr_ptr;
  assign o_wr_data = i_cap_data;

  assign o_finished      = (state == la_pkg::FINISHED);
  assign o_capture_start = trig_addr - pre_ptr;   // Oldest sample in window

  always_ff @(posedge i_cap_clk) begin
    if (rst) begin
      state     <= la_pkg::IDLE;
      wr_ptr    <= '0;
      hist_cnt  <= '0;
      rep_cnt   <= '0;
      trig_addr <= '0;
    end else if (!i_enable) begin
      // Dropping enable aborts or releases a capture
      state    <= la_pkg::IDLE;
      wr_ptr   <= '0;
      hist_cnt <= '0;
      rep_cnt  <= '0;
    end else begin
      case (state)
        la_pkg::IDLE, la_pkg::HISTORY: begin
          wr_ptr <= wr_ptr + 1'b1;
          if (hist_cnt != HIST_MAX) begin
            hist_cnt <= hist_cnt + 1'b1;  // Saturates once history is surely full
          end
          if (fire) begin
            trig_addr <= wr_ptr;
            // P = LA_DEPTH-1 makes the trigger sample the last one
            state <= (post_ptr == '0) ? la_pkg::FINISHED : la_pkg::CAPTURE;
          end else begin
            state <= la_pkg::HISTORY;
            if (count_evt) begin
              rep_cnt <= rep_cnt + 1'b1;
            end
          end
        end

        la_pkg::CAPTURE: begin
          wr_ptr <= wr_ptr + 1'b1;
          if (at_end) begin
            state <= la_pkg::FINISHED;
          end
        end

        la_pkg::FINISHED: begin
          state <= la_pkg::FINISHED;    // Held until enable falls
        end

        default: begin
          state <= la_pkg::IDLE;
        end
      endcase
    end
  end

endmodule

//--- rtl/la_sample_ram.sv
`timescale 1ns/100ps
`include "la_defs.svh"

module la_sample_ram (
  input  logic            i_cap_clk,
  input  logic            i_wr_en,
  input  la_pkg::ptr_t    i_wr_addr,
  input  la_pkg::sample_t i_wr_data,
  input  la_pkg::ptr_t    i_rd_addr,
  output la_pkg::sample_t o_rd_data
);

  la_pkg::sample_t mem [`LA_DEPTH];

  always_ff @(posedge i_cap_clk) begin
    if (i_wr_en) begin
      mem[i_wr_addr] <= i_wr_data;
    end
  end

  // One cycle read latency
  always_ff @(posedge i_cap_clk) begin
    o_rd_data <= mem[i_rd_addr];
  end

endmodule

//--- rtl/la_trigger_match.sv
`timescale 1ns/100ps
`include "la_defs.svh"

module la_trigger_match (
  input  logic            i_cap_clk,
  input  logic            rst,
  input  la_pkg::sample_t i_cap_data,
  input  la_pkg::sample_t i_trig_value,
  input  la_pkg::sample_t i_trig_mask,
  input  la_pkg::sample_t i_trig_edge,
  input  la_pkg::sample_t i_trig_both,
  output logic            o_match
);

  la_pkg::sample_t prev_data;
  la_pkg::sample_t bit_hit;

  // Last cycle's sample for edge detection
  always_ff @(posedge i_cap_clk) begin
    if (rst) begin
      prev_data <= '0;
    end else begin
      prev_data <= i_cap_data;
    end
  end

  for (genvar i = 0; i < `LA_SAMPLE_W; i++) begin : g_bit
    logic rise;
    logic fall;
    logic edge_hit;
    logic level_hit;

    assign rise = i_cap_data[i] & ~prev_data[i];
    assign fall = ~i_cap_data[i] & prev_data[i];

    // Value bit picks the direction unless both edges are enabled
    assign edge_hit = (i_trig_both[i] & (rise | fall)) |
                      (i_trig_value[i] & rise) |
                      (~i_trig_value[i] & fall);

    assign level_hit = ~(i_cap_data[i] ^ i_trig_value[i]);

    assign bit_hit[i] = ~i_trig_mask[i] |                      // Masked bits always match
                        (i_trig_edge[i] ? edge_hit : level_hit);
  end

  assign o_match = &bit_hit;

endmodule

//--- rtl/la_pkg.sv
`include "la_defs.svh"

package la_pkg;

  // One probe sample
  typedef logic [`LA_SAMPLE_W-1:0] sample_t;

  // Sample buffer address that wraps at LA_DEPTH
  typedef logic [`LA_DEPTH_LOG2-1:0] ptr_t;

  // Capture FSM
  typedef enum logic [1:0] {
    IDLE,
    HISTORY,   // Filling pre-trigger history and counting repeats
    CAPTURE,   // Filling the rest of the window after the trigger
    FINISHED
  } cap_state_e;

endpackage

//--- rtl/la_defs.svh
`ifndef LA_DEFS_SVH
`define LA_DEFS_SVH

// Probe bus width
`define LA_SAMPLE_W 32

// Sample buffer size
`define LA_DEPTH_LOG2 6
`define LA_DEPTH (1 << `LA_DEPTH_LOG2)

// Credits held by the readout after reset
`define LA_CREDITS 4

`endif
